// ==== logic/display_pkg.sv ====
package display_pkg;

    // display word and panel geometry.
    localparam int DATA_W      = 32;
    localparam int DIGIT_COUNT = 8;
    localparam int SEG_W       = 8;

    // derived sizes.
    localparam int NIBBLE_W    = DATA_W / DIGIT_COUNT;
    localparam int DIGIT_IDX_W = $clog2(DIGIT_COUNT);

    // segment bit positions, a-g in 0-6.
    localparam int SEG_DP_BIT  = 7;

    // source currently routed to the digits.
    typedef enum logic [2:0] {
        MODE_IDLE     = 3'd0,
        MODE_INSTR    = 3'd1,
        MODE_FLAGS    = 3'd2,
        MODE_RESULT   = 3'd3,
        MODE_MAX_ADDR = 3'd4
    } display_mode_e;

    // active-high a-g pattern for one hex nibble.
    function automatic logic [6:0] hex_to_seg(input logic [3:0] nibble);
        logic [6:0] seg;
        case (nibble)
            4'h0: seg = 7'h3F;
            4'h1: seg = 7'h06;
            4'h2: seg = 7'h5B;
            4'h3: seg = 7'h4F;
            4'h4: seg = 7'h66;
            4'h5: seg = 7'h6D;
            4'h6: seg = 7'h7D;
            4'h7: seg = 7'h07;
            4'h8: seg = 7'h7F;
            4'h9: seg = 7'h6F;
            4'hA: seg = 7'h77;
            4'hB: seg = 7'h7C;
            4'hC: seg = 7'h39;
            4'hD: seg = 7'h5E;
            4'hE: seg = 7'h79;
            default: seg = 7'h71;
        endcase
        return seg;
    endfunction

endpackage

// ==== logic/button_debounce.sv ====
`timescale 1ns/1ps

module button_debounce #(
    parameter int unsigned DEBOUNCE_CYCLES = 500000
) (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_raw,
    output logic o_level
);

    localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);
    localparam logic [CNT_W-1:0] CNT_LIMIT = CNT_W'(DEBOUNCE_CYCLES - 1);

    logic [1:0]       sync_q;
    logic [CNT_W-1:0] cnt_q;
    logic             differs;
    logic             cnt_done;

    // button is asynchronous to i_clk.
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            sync_q <= 2'b00;
        end else begin
            sync_q <= {sync_q[0], i_raw};
        end
    end

    assign differs  = sync_q[1] != o_level;
    assign cnt_done = cnt_q == CNT_LIMIT;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cnt_q   <= '0;
            o_level <= 1'b0;
        end else if (!differs) begin
            cnt_q <= '0; // any bounce restarts the count.
        end else if (cnt_done) begin
            cnt_q   <= '0;
            o_level <= sync_q[1];
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // accepted level only moves once the filter has run out.
    a_level_after_count: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (o_level != $past(o_level)) |-> $past(cnt_done && differs)
    );

endmodule

// ==== logic/display_mode_select.sv ====
`timescale 1ns/1ps

module display_mode_select (
    input  logic                         i_clk,
    input  logic                         i_rst_n,
    input  logic                         i_check_instr,
    input  logic                         i_check_flags,
    input  logic                         i_check_result,
    input  logic                         i_transmit_done,
    input  logic                         i_cpu_run,
    input  logic [7:0]                   i_pc,
    input  logic [7:0]                   i_opcode,
    input  logic [4:0]                   i_flags,
    input  logic [15:0]                  i_result_high,
    input  logic [15:0]                  i_result_low,
    input  logic [7:0]                   i_max_addr,
    output logic [display_pkg::DATA_W-1:0] o_display_word
);

    import display_pkg::*;

    display_mode_e state_q;
    display_mode_e state_d;
    logic          max_addr_req;

    // loader finished and CPU halted.
    assign max_addr_req = i_transmit_done && !i_cpu_run;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= MODE_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            MODE_IDLE: begin
                if (i_check_instr) begin
                    state_d = MODE_INSTR;
                end else if (i_check_flags) begin
                    state_d = MODE_FLAGS;
                end else if (i_check_result) begin
                    state_d = MODE_RESULT;
                end else if (max_addr_req) begin
                    state_d = MODE_MAX_ADDR;
                end
            end
            MODE_INSTR: begin
                if (!i_check_instr) begin
                    state_d = MODE_IDLE;
                end
            end
            MODE_FLAGS: begin
                if (!i_check_flags) begin
                    state_d = MODE_IDLE;
                end
            end
            MODE_RESULT: begin
                if (!i_check_result) begin
                    state_d = MODE_IDLE;
                end
            end
            MODE_MAX_ADDR: begin
                if (!max_addr_req) begin
                    state_d = MODE_IDLE;
                end
            end
            default: begin
                state_d = MODE_IDLE;
            end
        endcase
    end

    // word trails the state by one cycle.
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_display_word <= '0;
        end else begin
            case (state_q)
                MODE_INSTR: begin
                    o_display_word <= {{(DATA_W-16){1'b0}}, i_pc, i_opcode};
                end
                MODE_FLAGS: begin
                    o_display_word <= {{(DATA_W-5){1'b0}}, i_flags};
                end
                MODE_RESULT: begin
                    o_display_word <= {i_result_high, i_result_low};
                end
                MODE_MAX_ADDR: begin
                    o_display_word <= {{(DATA_W-8){1'b0}}, i_max_addr};
                end
                default: begin
                    o_display_word <= o_display_word; // idle keeps last value.
                end
            endcase
        end
    end

    a_state_legal: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        state_q inside {MODE_IDLE, MODE_INSTR, MODE_FLAGS, MODE_RESULT, MODE_MAX_ADDR}
    );

endmodule

// ==== logic/segment_scanner.sv ====
`timescale 1ns/1ps

module segment_scanner #(
    parameter int unsigned SCAN_INTERVAL = 49999
) (
    input  logic                              i_clk,
    input  logic                              i_rst_n,
    input  logic [display_pkg::DATA_W-1:0]      i_display_word,
    output logic [display_pkg::DIGIT_COUNT-1:0] o_digit_en,
    output logic [display_pkg::SEG_W-1:0]       o_segments
);

    import display_pkg::*;

    localparam int CNT_W = $clog2(SCAN_INTERVAL + 2);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(SCAN_INTERVAL);
    localparam logic [DIGIT_IDX_W-1:0] IDX_LAST = DIGIT_IDX_W'(DIGIT_COUNT - 1);

    logic                   scan_run_q;
    logic [CNT_W-1:0]       cnt_q;
    logic [DIGIT_IDX_W-1:0] digit_idx_q;
    logic                   cnt_wrap;
    logic [DIGIT_COUNT-1:0] digit_onehot;
    logic [NIBBLE_W-1:0]    nibble;
    logic [6:0]             seg_abcdefg;

    // first cycle after reset starts the scan.
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            scan_run_q <= 1'b0;
        end else begin
            scan_run_q <= 1'b1;
        end
    end

    assign cnt_wrap = scan_run_q && (cnt_q == CNT_LAST);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cnt_q <= '0;
        end else if (cnt_wrap) begin
            cnt_q <= '0;
        end else if (scan_run_q) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            digit_idx_q <= '0;
        end else if (cnt_wrap) begin
            if (digit_idx_q == IDX_LAST) begin
                digit_idx_q <= '0;
            end else begin
                digit_idx_q <= digit_idx_q + 1'b1;
            end
        end
    end

    always_comb begin
        digit_onehot = '0;
        digit_onehot[digit_idx_q] = 1'b1;
    end

    // digit k shows nibble k of the live word.
    assign nibble      = i_display_word[digit_idx_q*NIBBLE_W +: NIBBLE_W];
    assign seg_abcdefg = hex_to_seg(nibble);

    always_comb begin
        o_digit_en = '0;
        o_segments = '0;
        if (scan_run_q) begin
            o_digit_en = digit_onehot;
            o_segments[6:0] = seg_abcdefg;
        end
        o_segments[SEG_DP_BIT] = 1'b0; // no decimal point.
    end

    a_digit_onehot: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        scan_run_q |-> $onehot(o_digit_en)
    );

    // enable only steps at the end of an interval.
    a_step_on_wrap: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        ($past(scan_run_q) && (o_digit_en != $past(o_digit_en))) |-> $past(cnt_wrap)
    );

endmodule

// ==== logic/cpu_status_display.sv ====
`timescale 1ns/1ps

module cpu_status_display #(
    parameter int unsigned SCAN_INTERVAL   = 49999,
    parameter int unsigned DEBOUNCE_CYCLES = 500000
) (
    input  logic                              i_clk,
    input  logic                              i_rst_n,
    input  logic                              i_btn_instr,
    input  logic                              i_btn_flags,
    input  logic                              i_btn_result,
    input  logic                              i_transmit_done,
    input  logic                              i_cpu_run,
    input  logic [7:0]                        i_pc,
    input  logic [7:0]                        i_opcode,
    input  logic [4:0]                        i_flags,
    input  logic [15:0]                       i_result_high,
    input  logic [15:0]                       i_result_low,
    input  logic [7:0]                        i_max_addr,
    output logic [display_pkg::DIGIT_COUNT-1:0] o_digit_en,
    output logic [display_pkg::SEG_W-1:0]       o_segments
);

    import display_pkg::*;

    logic              check_instr;
    logic              check_flags;
    logic              check_result;
    logic [DATA_W-1:0] display_word;

    button_debounce #(
        .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
    ) instr_debounce_i (
        .i_clk  (i_clk),
        .i_rst_n(i_rst_n),
        .i_raw  (i_btn_instr),
        .o_level(check_instr)
    );

    button_debounce #(
        .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
    ) flags_debounce_i (
        .i_clk  (i_clk),
        .i_rst_n(i_rst_n),
        .i_raw  (i_btn_flags),
        .o_level(check_flags)
    );

    button_debounce #(
        .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
    ) result_debounce_i (
        .i_clk  (i_clk),
        .i_rst_n(i_rst_n),
        .i_raw  (i_btn_result),
        .o_level(check_result)
    );

    display_mode_select display_mode_select_i (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_check_instr  (check_instr),
        .i_check_flags  (check_flags),
        .i_check_result (check_result),
        .i_transmit_done(i_transmit_done),
        .i_cpu_run      (i_cpu_run),
        .i_pc           (i_pc),
        .i_opcode       (i_opcode),
        .i_flags        (i_flags),
        .i_result_high  (i_result_high),
        .i_result_low   (i_result_low),
        .i_max_addr     (i_max_addr),
        .o_display_word (display_word)
    );

    segment_scanner #(
        .SCAN_INTERVAL(SCAN_INTERVAL)
    ) segment_scanner_i (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_display_word(display_word),
        .o_digit_en    (o_digit_en),
        .o_segments    (o_segments)
    );

endmodule

// ==== verification/tb_cpu_status_display.sv ====
`timescale 1ns/1ps

module tb_cpu_status_display;

    import display_pkg::*;

    localparam int SCAN_INTERVAL   = 3;
    localparam int DEBOUNCE_CYCLES = 4;
    localparam int SETTLE_CYCLES   = DEBOUNCE_CYCLES + 8; // sync, filter, state, word.
    localparam int DIGIT_TIMEOUT   = DIGIT_COUNT * (SCAN_INTERVAL + 1) + 4;

    logic                   i_clk;
    logic                   i_rst_n;
    logic                   i_btn_instr;
    logic                   i_btn_flags;
    logic                   i_btn_result;
    logic                   i_transmit_done;
    logic                   i_cpu_run;
    logic [7:0]             i_pc;
    logic [7:0]             i_opcode;
    logic [4:0]             i_flags;
    logic [15:0]            i_result_high;
    logic [15:0]            i_result_low;
    logic [7:0]             i_max_addr;
    logic [DIGIT_COUNT-1:0] o_digit_en;
    logic [SEG_W-1:0]       o_segments;

    int unsigned            word_errors = 0;
    int unsigned            scan_errors = 0;
    int unsigned            timeouts    = 0;
    logic [15:0]            lfsr_state;
    display_mode_e          model_mode;
    logic [DATA_W-1:0]      model_word;
    logic [DIGIT_COUNT-1:0] prev_en = '0;
    int                     run_len = 0;

    cpu_status_display #(
        .SCAN_INTERVAL  (SCAN_INTERVAL),
        .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
    ) cpu_status_display_i (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_btn_instr    (i_btn_instr),
        .i_btn_flags    (i_btn_flags),
        .i_btn_result   (i_btn_result),
        .i_transmit_done(i_transmit_done),
        .i_cpu_run      (i_cpu_run),
        .i_pc           (i_pc),
        .i_opcode       (i_opcode),
        .i_flags        (i_flags),
        .i_result_high  (i_result_high),
        .i_result_low   (i_result_low),
        .i_max_addr     (i_max_addr),
        .o_digit_en     (o_digit_en),
        .o_segments     (o_segments)
    );

    initial begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    // length of the current digit, counted at falling edges.
    always @(negedge i_clk) begin
        if (o_digit_en != prev_en) begin
            run_len <= 1;
        end else begin
            run_len <= run_len + 1;
        end
        prev_en <= o_digit_en;
    end

    a_reset_quiet: assert property (
        @(negedge i_clk) !i_rst_n |-> (o_digit_en == '0 && o_segments == '0)
    ) else begin
        scan_errors++;
        $display("digit enables or segments are active during reset");
    end

    a_digit_onehot: assert property (
        @(negedge i_clk) disable iff (!i_rst_n)
        $past(i_rst_n) |-> $onehot(o_digit_en)
    ) else begin
        scan_errors++;
        $display("digit enable is not one-hot: %b", o_digit_en);
    end

    a_digit_hold: assert property (
        @(negedge i_clk) disable iff (!i_rst_n)
        (o_digit_en != prev_en && prev_en != '0) |-> run_len == SCAN_INTERVAL + 1
    ) else begin
        scan_errors++;
        $display("digit %b stayed on for %0d cycles", prev_en, run_len);
    end

    // galois form, taps 16 14 13 11.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;
        end
        return n;
    endfunction

    task automatic random_bits(input int count, output logic [31:0] v);
        int b;
        v = '0;
        for (b = 0; b < count; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v[b] = lfsr_state[0];
        end
    endtask

    function automatic logic [7:0] seg_pattern(input logic [3:0] n);
        case (n)
            4'h0: return 8'h3F;
            4'h1: return 8'h06;
            4'h2: return 8'h5B;
            4'h3: return 8'h4F;
            4'h4: return 8'h66;
            4'h5: return 8'h6D;
            4'h6: return 8'h7D;
            4'h7: return 8'h07;
            4'h8: return 8'h7F;
            4'h9: return 8'h6F;
            4'hA: return 8'h77;
            4'hB: return 8'h7C;
            4'hC: return 8'h39;
            4'hD: return 8'h5E;
            4'hE: return 8'h79;
            default: return 8'h71;
        endcase
    endfunction

    // bit 4 set when the pattern is a known digit.
    function automatic logic [4:0] seg_decode(input logic [7:0] seg);
        logic [4:0] r;
        int         n;
        r = 5'h00;
        for (n = 0; n < 16; n++) begin
            if (seg_pattern(4'(n)) == seg) begin
                r = {1'b1, 4'(n)};
            end
        end
        return r;
    endfunction

    function automatic display_mode_e next_mode(input display_mode_e mode);
        display_mode_e m;
        m = mode;
        case (mode)
            MODE_IDLE: begin
                if (i_btn_instr) begin
                    m = MODE_INSTR;
                end else if (i_btn_flags) begin
                    m = MODE_FLAGS;
                end else if (i_btn_result) begin
                    m = MODE_RESULT;
                end else if (i_transmit_done && !i_cpu_run) begin
                    m = MODE_MAX_ADDR;
                end
            end
            MODE_INSTR:    m = i_btn_instr ? mode : MODE_IDLE;
            MODE_FLAGS:    m = i_btn_flags ? mode : MODE_IDLE;
            MODE_RESULT:   m = i_btn_result ? mode : MODE_IDLE;
            default:       m = (i_transmit_done && !i_cpu_run) ? mode : MODE_IDLE;
        endcase
        return m;
    endfunction

    function automatic logic [31:0] mode_word(input display_mode_e mode,
                                              input logic [31:0] held);
        case (mode)
            MODE_INSTR:    return {16'h0000, i_pc, i_opcode};
            MODE_FLAGS:    return {27'h0, i_flags};
            MODE_RESULT:   return {i_result_high, i_result_low};
            MODE_MAX_ADDR: return {24'h0, i_max_addr};
            default:       return held; // idle keeps the last word.
        endcase
    endfunction

    // inputs are steady here, so three steps reach the settled state.
    task automatic update_model();
        repeat (3) begin
            model_word = mode_word(model_mode, model_word);
            model_mode = next_mode(model_mode);
        end
    endtask

    task automatic new_data();
        logic [31:0] pc;
        logic [31:0] op;
        logic [31:0] fl;
        logic [31:0] res;
        logic [31:0] ma;
        random_bits(8, pc);
        random_bits(8, op);
        random_bits(5, fl);
        random_bits(32, res);
        random_bits(8, ma);
        @(posedge i_clk);
        i_pc          <= pc[7:0];
        i_opcode      <= op[7:0];
        i_flags       <= fl[4:0];
        i_result_high <= res[31:16];
        i_result_low  <= res[15:0];
        i_max_addr    <= ma[7:0];
    endtask

    task automatic set_buttons(input logic instr, input logic flags, input logic result);
        @(posedge i_clk);
        i_btn_instr  <= instr;
        i_btn_flags  <= flags;
        i_btn_result <= result;
    endtask

    // model follows every input change once the DUT has settled.
    task automatic settle();
        repeat (SETTLE_CYCLES) @(posedge i_clk);
        update_model();
    endtask

    task automatic wait_digit(input int k, output logic found);
        logic [DIGIT_COUNT-1:0] want;
        int                     waited;
        want    = '0;
        want[k] = 1'b1;
        waited  = 0;
        @(negedge i_clk);
        while (o_digit_en != want && waited < DIGIT_TIMEOUT) begin
            @(negedge i_clk);
            waited++;
        end
        found = (o_digit_en == want);
    endtask

    task automatic capture_word(output logic [31:0] word, output logic ok);
        logic       found;
        logic [4:0] dec;
        int         k;
        word  = '0;
        ok    = 1'b1;
        found = 1'b1;
        for (k = 0; k < DIGIT_COUNT && found; k++) begin
            wait_digit(k, found);
            if (!found) begin
                timeouts++;
                ok = 1'b0;
                $display("timed out waiting for digit %0d to be enabled", k);
            end else begin
                dec = seg_decode(o_segments);
                if (!dec[4]) begin
                    scan_errors++;
                    ok = 1'b0;
                    $display("digit %0d shows pattern %02h, not a hex digit", k, o_segments);
                end
                word[k*4 +: 4] = dec[3:0];
            end
        end
    endtask

    task automatic check_word(input string name);
        logic [31:0] got;
        logic        ok;
        capture_word(got, ok);
        if (ok) begin
            assert (got == model_word) else begin
                word_errors++;
                $display("** Error %s: expected %08h, actual %08h", name, model_word, got);
            end
        end
    endtask

    initial begin
        i_rst_n         = 1'b0;
        i_btn_instr     = 1'b0;
        i_btn_flags     = 1'b0;
        i_btn_result    = 1'b0;
        i_transmit_done = 1'b0;
        i_cpu_run       = 1'b0;
        i_pc            = '0;
        i_opcode        = '0;
        i_flags         = '0;
        i_result_high   = '0;
        i_result_low    = '0;
        i_max_addr      = '0;
        lfsr_state      = 16'd54;
        model_mode      = MODE_IDLE;
        model_word      = '0;
        repeat (10) @(posedge i_clk);
        i_rst_n <= 1'b1;

        check_word("reset_scan");

        new_data();
        set_buttons(1'b1, 1'b0, 1'b0);
        settle();
        check_word("instr_view");
        set_buttons(1'b0, 1'b0, 1'b0);
        settle();
        new_data(); // word must ignore data once released.
        settle();
        check_word("instr_hold");

        set_buttons(1'b1, 1'b1, 1'b0);
        settle();
        check_word("priority_instr");
        set_buttons(1'b0, 1'b0, 1'b0);
        settle();
        new_data();
        set_buttons(1'b0, 1'b1, 1'b0);
        settle();
        check_word("flags_view");
        set_buttons(1'b0, 1'b0, 1'b0);
        settle();

        new_data();
        set_buttons(1'b0, 1'b0, 1'b1);
        settle();
        check_word("result_view");
        new_data();
        settle();
        check_word("result_live");
        set_buttons(1'b0, 1'b0, 1'b0);
        settle();

        new_data();
        @(posedge i_clk);
        i_transmit_done <= 1'b1;
        settle();
        check_word("max_addr_view");
        @(posedge i_clk);
        i_cpu_run <= 1'b1;
        settle();
        check_word("max_addr_run");
        @(posedge i_clk);
        i_transmit_done <= 1'b0;
        i_cpu_run       <= 1'b0;
        settle();

        new_data();
        settle();
        @(posedge i_clk);
        i_btn_instr <= 1'b1;
        repeat (DEBOUNCE_CYCLES - 1) @(posedge i_clk);
        i_btn_instr <= 1'b0; // shorter than the filter.
        settle();
        check_word("short_pulse");

        $display("errors: %0d word, %0d scan, %0d timeout", word_errors, scan_errors, timeouts);
        if (word_errors == 0 && scan_errors == 0 && timeouts == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
logic/display_pkg.sv
logic/button_debounce.sv
logic/display_mode_select.sv
logic/segment_scanner.sv
logic/cpu_status_display.sv
verification/tb_cpu_status_display.sv

// ==== Makefile ====
TOP := tb_cpu_status_display

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module $(TOP)
	verilator --lint-only -f tb.f --top-module cpu_status_display

clean:
	rm -rf obj_dir sim.log
